/* ahb_iopmp.sv */
// ========================================
// AHB IOPMP, two channels.
// Config register block plus one gating
// channel per slave/master pair.
// ========================================
`timescale 1ns/1ps

module ahb_iopmp (
    input  logic                 hclk_i,
    input  logic                 hresetn_i,

    // config port.
    input  logic                 hsel_i,
    input  iopmp_pkg::addr_t     haddr_i,
    input  logic                 hwrite_i,
    input  iopmp_pkg::data_t     hwdata_i,
    output iopmp_pkg::hresp_e    hresp_o,
    output logic                 hready_o,
    output iopmp_pkg::data_t     hrdata_o,

    input  iopmp_pkg::ahb_req_t  s0_req_i,
    output iopmp_pkg::ahb_rsp_t  s0_rsp_o,
    input  iopmp_pkg::ahb_req_t  s1_req_i,
    output iopmp_pkg::ahb_rsp_t  s1_rsp_o,

    output iopmp_pkg::ahb_req_t  m0_req_o,
    input  iopmp_pkg::ahb_rsp_t  m0_rsp_i,
    output iopmp_pkg::ahb_req_t  m1_req_o,
    input  iopmp_pkg::ahb_rsp_t  m1_rsp_i
);

    iopmp_pkg::pmp_ctrl_t       ctrl0;
    iopmp_pkg::pmp_ctrl_t       ctrl1;
    iopmp_pkg::pmp_region_arr_t regions0;
    iopmp_pkg::pmp_region_arr_t regions1;
    iopmp_pkg::pmp_stat_t       stat0;
    iopmp_pkg::pmp_stat_t       stat1;
    iopmp_pkg::addr_t           dump0_w;
    iopmp_pkg::addr_t           dump0_r;
    iopmp_pkg::addr_t           dump1_w;
    iopmp_pkg::addr_t           dump1_r;

    // config accesses never wait and never fail.
    assign hready_o = 1'b1;
    assign hresp_o  = iopmp_pkg::OKAY;

    assign s0_rsp_o = m0_rsp_i;
    assign s1_rsp_o = m1_rsp_i;

    iopmp_cfg_regs u_cfg_regs (
        .hclk_i     (hclk_i),
        .hresetn_i  (hresetn_i),
        .hsel_i     (hsel_i),
        .haddr_i    (haddr_i),
        .hwrite_i   (hwrite_i),
        .hwdata_i   (hwdata_i),
        .hrdata_o   (hrdata_o),
        .ctrl0_o    (ctrl0),
        .ctrl1_o    (ctrl1),
        .regions0_o (regions0),
        .regions1_o (regions1),
        .stat0_i    (stat0),
        .stat1_i    (stat1),
        .dump0_w_i  (dump0_w),
        .dump0_r_i  (dump0_r),
        .dump1_w_i  (dump1_w),
        .dump1_r_i  (dump1_r)
    );

    iopmp_channel u_ch0 (
        .hclk_i    (hclk_i),
        .hresetn_i (hresetn_i),
        .ctrl_i    (ctrl0),
        .regions_i (regions0),
        .s_req_i   (s0_req_i),
        .m_req_o   (m0_req_o),
        .stat_o    (stat0),
        .dump_w_o  (dump0_w),
        .dump_r_o  (dump0_r)
    );

    iopmp_channel u_ch1 (
        .hclk_i    (hclk_i),
        .hresetn_i (hresetn_i),
        .ctrl_i    (ctrl1),
        .regions_i (regions1),
        .s_req_i   (s1_req_i),
        .m_req_o   (m1_req_o),
        .stat_o    (stat1),
        .dump_w_o  (dump1_w),
        .dump_r_o  (dump1_r)
    );

endmodule

/* files.f */
+incdir+.
iopmp_pkg.sv
iopmp_cfg_regs.sv
iopmp_channel.sv
ahb_iopmp.sv
iopmp_assertions.sv
tb_ahb_iopmp.sv

/* iopmp_assertions.sv */
// ========================================
// IOPMP protocol assertions.
// Config port response and channel gating,
// bound onto the top level.
// ========================================
`timescale 1ns/1ps

module iopmp_assertions (
    input logic                hclk_i,
    input logic                hresetn_i,
    input logic                hready_i,
    input iopmp_pkg::hresp_e   hresp_i,
    input iopmp_pkg::ahb_req_t s0_req_i,
    input iopmp_pkg::ahb_req_t s1_req_i,
    input iopmp_pkg::ahb_req_t m0_req_i,
    input iopmp_pkg::ahb_req_t m1_req_i
);

    a_hready: assert property (@(posedge hclk_i) disable iff (!hresetn_i) hready_i)
        else $error("config hready went low");

    a_hresp: assert property (@(posedge hclk_i) disable iff (!hresetn_i)
        hresp_i == iopmp_pkg::OKAY)
        else $error("config hresp is not OKAY");

    // a forwarded transfer keeps the slave's htrans.
    a_gate0: assert property (@(posedge hclk_i) disable iff (!hresetn_i)
        m0_req_i.htrans != iopmp_pkg::IDLE |-> m0_req_i.htrans == s0_req_i.htrans)
        else $error("channel 0 forwarded an htrans the slave did not issue");

    a_gate1: assert property (@(posedge hclk_i) disable iff (!hresetn_i)
        m1_req_i.htrans != iopmp_pkg::IDLE |-> m1_req_i.htrans == s1_req_i.htrans)
        else $error("channel 1 forwarded an htrans the slave did not issue");

endmodule

bind ahb_iopmp iopmp_assertions u_assertions (
    .hclk_i    (hclk_i),
    .hresetn_i (hresetn_i),
    .hready_i  (hready_o),
    .hresp_i   (hresp_o),
    .s0_req_i  (s0_req_i),
    .s1_req_i  (s1_req_i),
    .m0_req_i  (m0_req_o),
    .m1_req_i  (m1_req_o)
);

/* iopmp_cfg_regs.sv */
// ========================================
// IOPMP config register block.
// AHB-side write/read decode of control,
// status, dump and region registers.
// ========================================
`timescale 1ns/1ps
`include "iopmp_macros.svh"

module iopmp_cfg_regs (
    input  logic                        hclk_i,
    input  logic                        hresetn_i,

    input  logic                        hsel_i,
    input  iopmp_pkg::addr_t            haddr_i,
    input  logic                        hwrite_i,
    input  iopmp_pkg::data_t            hwdata_i,
    output iopmp_pkg::data_t            hrdata_o,

    output iopmp_pkg::pmp_ctrl_t        ctrl0_o,
    output iopmp_pkg::pmp_ctrl_t        ctrl1_o,
    output iopmp_pkg::pmp_region_arr_t  regions0_o,
    output iopmp_pkg::pmp_region_arr_t  regions1_o,

    input  iopmp_pkg::pmp_stat_t        stat0_i,
    input  iopmp_pkg::pmp_stat_t        stat1_i,
    input  iopmp_pkg::addr_t            dump0_w_i,
    input  iopmp_pkg::addr_t            dump0_r_i,
    input  iopmp_pkg::addr_t            dump1_w_i,
    input  iopmp_pkg::addr_t            dump1_r_i
);

    typedef logic [`IOPMP_REG_BITS-1:0] reg_off_t;

    iopmp_pkg::pmp_ctrl_t       ctrl_q    [`IOPMP_NUM_CH];
    iopmp_pkg::pmp_region_arr_t regions_q [`IOPMP_NUM_CH];

    iopmp_pkg::pmp_stat_t       stat      [`IOPMP_NUM_CH];
    iopmp_pkg::addr_t           dump_w    [`IOPMP_NUM_CH];
    iopmp_pkg::addr_t           dump_r    [`IOPMP_NUM_CH];

    logic                       wr_pend_q;
    reg_off_t                   wr_off_q;
    reg_off_t                   rd_off;
    iopmp_pkg::data_t           rd_data;
    iopmp_pkg::pmp_ctrl_t       ctrl_wr;

    assign stat[0]   = stat0_i;
    assign stat[1]   = stat1_i;
    assign dump_w[0] = dump0_w_i;
    assign dump_w[1] = dump1_w_i;
    assign dump_r[0] = dump0_r_i;
    assign dump_r[1] = dump1_r_i;

    assign ctrl0_o    = ctrl_q[0];
    assign ctrl1_o    = ctrl_q[1];
    assign regions0_o = regions_q[0];
    assign regions1_o = regions_q[1];

    // address phase of a config write.
    always_ff @(posedge hclk_i or negedge hresetn_i) begin
        if (!hresetn_i) begin
            wr_pend_q <= 1'b0;
            wr_off_q  <= '0;
        end else begin
            wr_pend_q <= hsel_i & hwrite_i;
            if (hsel_i && hwrite_i) begin
                wr_off_q <= haddr_i[`IOPMP_REG_BITS-1:0];
            end
        end
    end

    always_comb begin
        ctrl_wr      = hwdata_i;
        ctrl_wr.rsvd = '0; // reserved bits stay zero.
    end

    // hwdata_i lands at the offset from the address phase.
    always_ff @(posedge hclk_i or negedge hresetn_i) begin
        if (!hresetn_i) begin
            for (int c = 0; c < `IOPMP_NUM_CH; c++) begin
                ctrl_q[c]    <= '0;
                regions_q[c] <= '0;
            end
        end else if (wr_pend_q) begin
            for (int c = 0; c < `IOPMP_NUM_CH; c++) begin
                if (wr_off_q == reg_off_t'(`IOPMP_REG_CTRL + 4 * c)) begin
                    ctrl_q[c] <= ctrl_wr;
                end
                for (int r = 0; r < `IOPMP_NUM_REGIONS; r++) begin
                    if (wr_off_q == reg_off_t'(`IOPMP_REG_CONF + `IOPMP_CONF_STRIDE * c
                                               + 8 * r)) begin
                        regions_q[c][r].base <= hwdata_i;
                    end
                    if (wr_off_q == reg_off_t'(`IOPMP_REG_CONF + `IOPMP_CONF_STRIDE * c
                                               + 8 * r + 4)) begin
                        regions_q[c][r].mask <= hwdata_i;
                    end
                end
            end
        end
    end

    // undefined offsets read as zero.
    always_comb begin
        rd_off  = haddr_i[`IOPMP_REG_BITS-1:0];
        rd_data = '0;
        for (int c = 0; c < `IOPMP_NUM_CH; c++) begin
            if (rd_off == reg_off_t'(`IOPMP_REG_CTRL + 4 * c)) begin
                rd_data = ctrl_q[c];
            end
            if (rd_off == reg_off_t'(`IOPMP_REG_STAT + 4 * c)) begin
                rd_data = stat[c];
            end
            if (rd_off == reg_off_t'(`IOPMP_REG_DUMP + 8 * c)) begin
                rd_data = dump_w[c];
            end
            if (rd_off == reg_off_t'(`IOPMP_REG_DUMP + 8 * c + 4)) begin
                rd_data = dump_r[c];
            end
            for (int r = 0; r < `IOPMP_NUM_REGIONS; r++) begin
                if (rd_off == reg_off_t'(`IOPMP_REG_CONF + `IOPMP_CONF_STRIDE * c + 8 * r)) begin
                    rd_data = regions_q[c][r].base;
                end
                if (rd_off == reg_off_t'(`IOPMP_REG_CONF + `IOPMP_CONF_STRIDE * c
                                         + 8 * r + 4)) begin
                    rd_data = regions_q[c][r].mask;
                end
            end
        end
    end

    always_ff @(posedge hclk_i or negedge hresetn_i) begin
        if (!hresetn_i) begin
            hrdata_o <= '0;
        end else if (hsel_i && !hwrite_i) begin
            hrdata_o <= rd_data; // held until the next read.
        end
    end

endmodule

/* iopmp_channel.sv */
// ========================================
// IOPMP channel.
// Region match, htrans gating and status
// recording for one slave/master pair.
// ========================================
`timescale 1ns/1ps
`include "iopmp_macros.svh"

module iopmp_channel (
    input  logic                        hclk_i,
    input  logic                        hresetn_i,

    input  iopmp_pkg::pmp_ctrl_t        ctrl_i,
    input  iopmp_pkg::pmp_region_arr_t  regions_i,

    input  iopmp_pkg::ahb_req_t         s_req_i,
    output iopmp_pkg::ahb_req_t         m_req_o,

    output iopmp_pkg::pmp_stat_t        stat_o,
    output iopmp_pkg::addr_t            dump_w_o,
    output iopmp_pkg::addr_t            dump_r_o
);

    iopmp_pkg::region_vec_t match;
    iopmp_pkg::region_vec_t hit_w;
    iopmp_pkg::region_vec_t hit_r;
    logic                   dir_hit;
    logic                   active;
    logic                   miss_w;
    logic                   miss_r;

    iopmp_pkg::region_vec_t hit_w_q;
    iopmp_pkg::region_vec_t hit_r_q;
    logic                   err_w_q;
    logic                   err_r_q;
    iopmp_pkg::addr_t       dump_w_q;
    iopmp_pkg::addr_t       dump_r_q;

    always_comb begin
        for (int i = 0; i < `IOPMP_NUM_REGIONS; i++) begin
            match[i] = (s_req_i.haddr & regions_i[i].mask) == regions_i[i].base;
        end
    end

    assign hit_w = ctrl_i.en_w & match & {`IOPMP_NUM_REGIONS{s_req_i.hwrite}};
    assign hit_r = ctrl_i.en_r & match & {`IOPMP_NUM_REGIONS{~s_req_i.hwrite}};

    assign dir_hit = s_req_i.hwrite ? |hit_w : |hit_r;
    assign active  = s_req_i.htrans != iopmp_pkg::IDLE;

    // refused transfers of each direction.
    assign miss_w = active & s_req_i.hwrite & ~(|hit_w);
    assign miss_r = active & ~s_req_i.hwrite & ~(|hit_r);

    always_comb begin
        m_req_o = s_req_i;
        if (!dir_hit) begin
            m_req_o.htrans = iopmp_pkg::IDLE;
        end
    end

    // repeats under back-pressure record the same values again.
    always_ff @(posedge hclk_i or negedge hresetn_i) begin
        if (!hresetn_i) begin
            hit_w_q  <= '0;
            hit_r_q  <= '0;
            err_w_q  <= 1'b0;
            err_r_q  <= 1'b0;
            dump_w_q <= '0;
            dump_r_q <= '0;
        end else if (ctrl_i.rst) begin
            hit_w_q  <= '0;
            hit_r_q  <= '0;
            err_w_q  <= 1'b0;
            err_r_q  <= 1'b0;
            dump_w_q <= '0;
            dump_r_q <= '0;
        end else if (active) begin
            if (|hit_w) begin
                hit_w_q <= hit_w;
            end
            if (|hit_r) begin
                hit_r_q <= hit_r;
            end
            if (miss_w) begin
                err_w_q  <= 1'b1; // sticky.
                dump_w_q <= s_req_i.haddr;
            end
            if (miss_r) begin
                err_r_q  <= 1'b1;
                dump_r_q <= s_req_i.haddr;
            end
        end
    end

    always_comb begin
        stat_o       = '0;
        stat_o.hit_w = hit_w_q;
        stat_o.hit_r = hit_r_q;
        stat_o.err_w = err_w_q;
        stat_o.err_r = err_r_q;
    end

    assign dump_w_o = dump_w_q;
    assign dump_r_o = dump_r_q;

endmodule

/* iopmp_macros.svh */
// ========================================
// AHB IOPMP parameters.
// Bus widths, region and channel counts,
// and the config register map offsets.
// ========================================
`ifndef IOPMP_MACROS_SVH
`define IOPMP_MACROS_SVH

`define IOPMP_AW          32
`define IOPMP_DW          32
`define IOPMP_NUM_REGIONS 8
`define IOPMP_NUM_CH      2

// low config address bits that are decoded.
`define IOPMP_REG_BITS    8

`define IOPMP_REG_CTRL    8'h00 // one word per channel.
`define IOPMP_REG_STAT    8'h08 // one word per channel.
`define IOPMP_REG_DUMP    8'h10 // write dump, then read dump, per channel.
`define IOPMP_REG_CONF    8'h20 // base at 8*region, mask at 8*region+4.
`define IOPMP_CONF_STRIDE 8'h40 // region space per channel.

`endif

/* iopmp_pkg.sv */
// ========================================
// AHB IOPMP types.
// Bus vectors, AHB encodings, register
// words and the AHB request/response.
// ========================================
`include "iopmp_macros.svh"

package iopmp_pkg;

    typedef logic [`IOPMP_AW-1:0]          addr_t;
    typedef logic [`IOPMP_DW-1:0]          data_t;
    typedef logic [`IOPMP_NUM_REGIONS-1:0] region_vec_t;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [1:0] {
        OKAY  = 2'b00,
        ERROR = 2'b01,
        RETRY = 2'b10,
        SPLIT = 2'b11
    } hresp_e;

    typedef struct packed {
        region_vec_t                               en_w;
        region_vec_t                               en_r;
        logic [`IOPMP_DW-2*`IOPMP_NUM_REGIONS-2:0] rsvd;
        logic                                      rst;
    } pmp_ctrl_t;

    typedef struct packed {
        region_vec_t                               hit_w;
        region_vec_t                               hit_r;
        logic [`IOPMP_DW-2*`IOPMP_NUM_REGIONS-3:0] rsvd;
        logic                                      err_w;
        logic                                      err_r;
    } pmp_stat_t;

    typedef struct packed {
        addr_t mask;
        addr_t base;
    } pmp_region_t;

    typedef pmp_region_t [`IOPMP_NUM_REGIONS-1:0] pmp_region_arr_t;

    typedef struct packed {
        addr_t      haddr;
        logic [3:0] hprot;
        logic [2:0] hsize;
        htrans_e    htrans;
        logic [2:0] hburst;
        logic       hwrite;
        data_t      hwdata;
    } ahb_req_t;

    typedef struct packed {
        hresp_e hresp;
        logic   hgrant;
        logic   hready;
        data_t  hrdata;
    } ahb_rsp_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the IOPMP testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ahb_iopmp -f files.f -o sim_tb \
    || { echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log

grep -qx "Test passed" sim.log && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }

/* tb_ahb_iopmp.sv */
// ========================================
// AHB IOPMP testbench.
// LFSR-driven config and bus traffic,
// checked against a reference model.
// ========================================
`timescale 1ns/1ps
`include "iopmp_macros.svh"

module tb_ahb_iopmp;

    localparam int MAX_CYCLES = 20000; // about four times the test length.

    logic                hclk_i;
    logic                hresetn_i;
    logic                hsel_i;
    logic                hwrite_i;
    logic                hready_o;
    iopmp_pkg::addr_t    haddr_i;
    iopmp_pkg::data_t    hwdata_i;
    iopmp_pkg::data_t    hrdata_o;
    iopmp_pkg::hresp_e   hresp_o;
    iopmp_pkg::ahb_req_t s0_req_i;
    iopmp_pkg::ahb_req_t s1_req_i;
    iopmp_pkg::ahb_req_t m0_req_o;
    iopmp_pkg::ahb_req_t m1_req_o;
    iopmp_pkg::ahb_rsp_t s0_rsp_o;
    iopmp_pkg::ahb_rsp_t s1_rsp_o;
    iopmp_pkg::ahb_rsp_t m0_rsp_i;
    iopmp_pkg::ahb_rsp_t m1_rsp_i;

    logic [31:0] lfsr;
    int          cycles;
    int          checks;
    int          errors;
    int          tests_failed;
    int          start;

    // reference model state.
    iopmp_pkg::data_t       ctrl_m  [`IOPMP_NUM_CH];
    iopmp_pkg::addr_t       base_m  [`IOPMP_NUM_CH][`IOPMP_NUM_REGIONS];
    iopmp_pkg::addr_t       mask_m  [`IOPMP_NUM_CH][`IOPMP_NUM_REGIONS];
    iopmp_pkg::region_vec_t hitw_m  [`IOPMP_NUM_CH];
    iopmp_pkg::region_vec_t hitr_m  [`IOPMP_NUM_CH];
    logic                   errw_m  [`IOPMP_NUM_CH];
    logic                   errr_m  [`IOPMP_NUM_CH];
    iopmp_pkg::addr_t       dumpw_m [`IOPMP_NUM_CH];
    iopmp_pkg::addr_t       dumpr_m [`IOPMP_NUM_CH];

    ahb_iopmp UUT (.*);

    initial begin
        hclk_i = 1'b0;
        forever #10 hclk_i = ~hclk_i;
    end

    always @(posedge hclk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // galois lfsr stepped once per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int region_off(input int ch, input int r);
        return `IOPMP_REG_CONF + `IOPMP_CONF_STRIDE * ch + 8 * r;
    endfunction

    task automatic check(input string name, input logic [79:0] got, input logic [79:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic bus_write(input int off, input iopmp_pkg::data_t d);
        hsel_i   = 1'b1;
        hwrite_i = 1'b1;
        haddr_i  = off;
        @(posedge hclk_i) #2;
        hsel_i   = 1'b0;
        hwrite_i = 1'b0;
        hwdata_i = d; // data phase.
        @(posedge hclk_i) #2;
    endtask

    task automatic read_check(input int off, input iopmp_pkg::data_t exp);
        hsel_i   = 1'b1;
        hwrite_i = 1'b0;
        haddr_i  = off;
        @(posedge hclk_i) #2;
        hsel_i   = 1'b0;
        check($sformatf("hrdata_o[0x%0h]", off), 80'(hrdata_o), 80'(exp));
        check("hready_o", 80'(hready_o), 80'(1'b1));
        check("hresp_o", 80'(hresp_o), 80'(iopmp_pkg::OKAY));
    endtask

    task automatic clear_model(input int ch);
        hitw_m[ch]  = '0;
        hitr_m[ch]  = '0;
        errw_m[ch]  = 1'b0;
        errr_m[ch]  = 1'b0;
        dumpw_m[ch] = '0;
        dumpr_m[ch] = '0;
    endtask

    task automatic write_ctrl(input int ch, input iopmp_pkg::data_t v);
        bus_write(`IOPMP_REG_CTRL + 4 * ch, v);
        ctrl_m[ch] = v & 32'hFFFF_0001; // reserved bits read zero.
        if (v[0]) clear_model(ch);
    endtask

    task automatic write_region(input int ch, input int r, input iopmp_pkg::addr_t base,
                                input iopmp_pkg::addr_t mask);
        bus_write(region_off(ch, r), base);
        bus_write(region_off(ch, r) + 4, mask);
        base_m[ch][r] = base;
        mask_m[ch][r] = mask;
    endtask

    // 64-byte windows inside a 1 KiB space, so requests hit and miss.
    task automatic setup_windows(input int ch);
        for (int r = 0; r < `IOPMP_NUM_REGIONS; r++) begin
            write_region(ch, r, {22'd0, 10'(rand_bits(10))} & 32'hFFFF_FFC0, 32'hFFFF_FFC0);
        end
        write_ctrl(ch, {8'(rand_bits(8)), 8'(rand_bits(8)), 16'd0});
    endtask

    function automatic iopmp_pkg::ahb_req_t model_step(input int ch,
                                                       input iopmp_pkg::ahb_req_t req);
        iopmp_pkg::region_vec_t hw;
        iopmp_pkg::region_vec_t hr;
        iopmp_pkg::ahb_req_t    exp;
        logic                   refused;
        hw = '0;
        hr = '0;
        for (int i = 0; i < `IOPMP_NUM_REGIONS; i++) begin
            if ((req.haddr & mask_m[ch][i]) == base_m[ch][i]) begin
                hw[i] = req.hwrite & ctrl_m[ch][24 + i];
                hr[i] = !req.hwrite & ctrl_m[ch][16 + i];
            end
        end
        refused = req.hwrite ? (hw == '0) : (hr == '0);
        exp     = req;
        if (refused) exp.htrans = iopmp_pkg::IDLE;
        if (req.htrans != iopmp_pkg::IDLE && !ctrl_m[ch][0]) begin
            if (hw != '0) hitw_m[ch] = hw;
            if (hr != '0) hitr_m[ch] = hr;
            if (refused && req.hwrite) begin
                errw_m[ch]  = 1'b1;
                dumpw_m[ch] = req.haddr;
            end
            if (refused && !req.hwrite) begin
                errr_m[ch]  = 1'b1;
                dumpr_m[ch] = req.haddr;
            end
        end
        return exp;
    endfunction

    task automatic traffic(input int n, input logic opposite);
        logic                w0;
        iopmp_pkg::ahb_req_t e0;
        iopmp_pkg::ahb_req_t e1;
        repeat (n) begin
            w0       = 1'(rand_bits(1));
            s0_req_i = {22'd0, 10'(rand_bits(10)), 12'(rand_bits(12)), w0, rand_bits(32)};
            s1_req_i = {22'd0, 10'(rand_bits(10)), 12'(rand_bits(12)),
                        opposite ? !w0 : 1'(rand_bits(1)), rand_bits(32)};
            m0_rsp_i = {4'(rand_bits(4)), rand_bits(32)};
            m1_rsp_i = {4'(rand_bits(4)), rand_bits(32)};
            e0       = model_step(0, s0_req_i);
            e1       = model_step(1, s1_req_i);
            #8;
            check("m0_req_o", 80'(m0_req_o), 80'(e0));
            check("m1_req_o", 80'(m1_req_o), 80'(e1));
            check("s0_rsp_o", 80'(s0_rsp_o), 80'(m0_rsp_i));
            check("s1_rsp_o", 80'(s1_rsp_o), 80'(m1_rsp_i));
            @(posedge hclk_i) #2;
        end
        s0_req_i = '0;
        s1_req_i = '0;
    endtask

    task automatic check_status(input int ch);
        read_check(`IOPMP_REG_STAT + 4 * ch,
                   {hitw_m[ch], hitr_m[ch], 14'd0, errw_m[ch], errr_m[ch]});
        read_check(`IOPMP_REG_DUMP + 8 * ch, dumpw_m[ch]);
        read_check(`IOPMP_REG_DUMP + 8 * ch + 4, dumpr_m[ch]);
    endtask

    task automatic report(input string name, input int first);
        if (errors == first) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - first);
            tests_failed++;
        end
    endtask

    initial begin
        lfsr      = 32'd82608;
        hresetn_i = 1'b0;
        hsel_i    = 1'b0;
        hwrite_i  = 1'b0;
        haddr_i   = '0;
        hwdata_i  = '0;
        s0_req_i  = '0;
        s1_req_i  = '0;
        m0_rsp_i  = '0;
        m1_rsp_i  = '0;
        for (int c = 0; c < `IOPMP_NUM_CH; c++) begin
            ctrl_m[c] = '0;
            clear_model(c);
            for (int r = 0; r < `IOPMP_NUM_REGIONS; r++) begin
                base_m[c][r] = '0;
                mask_m[c][r] = '0;
            end
        end
        repeat (10) @(posedge hclk_i);
        #2 hresetn_i = 1'b1;

        start = errors;
        for (int off = 0; off < 256; off += 4) read_check(off, '0);
        traffic(50, 1'b0); // everything blocked.
        report("reset", start);

        start = errors;
        repeat (8) begin
            for (int c = 0; c < `IOPMP_NUM_CH; c++) begin
                write_ctrl(c, rand_bits(32));
                for (int r = 0; r < `IOPMP_NUM_REGIONS; r++) begin
                    write_region(c, r, rand_bits(32), rand_bits(32));
                end
            end
            for (int c = 0; c < `IOPMP_NUM_CH; c++) begin
                read_check(`IOPMP_REG_CTRL + 4 * c, ctrl_m[c]);
                for (int r = 0; r < `IOPMP_NUM_REGIONS; r++) begin
                    read_check(region_off(c, r), base_m[c][r]);
                    read_check(region_off(c, r) + 4, mask_m[c][r]);
                end
            end
            for (int off = 'hA0; off < 256; off += 4) read_check(off, '0);
        end
        report("readback", start);

        start = errors;
        repeat (4) begin
            setup_windows(0);
            setup_windows(1);
            traffic(400, 1'b0);
        end
        report("gating", start);

        start = errors;
        repeat (4) begin
            setup_windows(0);
            setup_windows(1);
            traffic(200, 1'b1); // opposite directions on the two channels.
            check_status(0);
            check_status(1);
        end
        report("status", start);

        start = errors;
        write_ctrl(0, ctrl_m[0] | 32'h1);
        @(posedge hclk_i) #2; // the clear lands one edge after the write.
        check_status(0);
        check_status(1);
        write_ctrl(0, ctrl_m[0] & ~32'h1);
        traffic(200, 1'b0);
        check_status(0);
        check_status(1);
        report("clear", start);

        $display("tests run 5, tests failed %0d, checks %0d, errors %0d",
                 tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
